// File: aes_settings.svh
// Build-wide constants of the AES-128 core.
// Round count and the fixed start-to-valid latency.
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// Number of cipher rounds for a 128-bit key.
`define AES_ROUNDS 10

// Cycles from the start edge to the result flag.
// One capture cycle plus two register stages in every round.
`define AES_LATENCY 21

`endif

// File: aes_data_pkg.sv
// Datapath types of the AES-128 core.
// Byte, column, block, round constant and round-key types, plus the GF(2^8) doubling.
package aes_data_pkg;

    typedef logic [7:0] aes_byte_t;

    // One state column, row 0 in the top byte.
    typedef logic [31:0] aes_word_t;

    // A full state or key as four columns, column 0 most significant.
    typedef logic [0:3][31:0] aes_block_t;

    typedef logic [7:0] aes_rcon_t;

    // Key-schedule stage output.
    // The next field feeds the following stage, now lines up with the current round.
    typedef struct packed {
        aes_block_t next;
        aes_block_t now;
    } aes_round_key_t;

    // Multiplication by x in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1.
    function automatic aes_byte_t aes_xtime(aes_byte_t a);
        aes_byte_t r;
        r = {a[6:0], 1'b0};
        if (a[7])
        begin
            r = r ^ 8'h1b;  // Reduce by the field polynomial.
        end
        return r;
    endfunction

endpackage

// File: aes_ctrl_pkg.sv
// Control types of the AES-128 core.
// Completion FSM states and the flagged result bundle.
package aes_ctrl_pkg;

    // The FSM idles after reset, counts while busy and holds in done.
    typedef enum logic [1:0] {
        ctrl_idle = 2'd0,
        ctrl_busy = 2'd1,
        ctrl_done = 2'd2
    } aes_ctrl_state_t;

    // Ciphertext with its valid flag, 129 bits in all.
    typedef struct packed {
        logic                     valid;
        aes_data_pkg::aes_block_t data;
    } aes_result_t;

endpackage

// File: aes_sbox.sv
// Word-wide AES S-box with a registered output.
// Each byte is inverted in GF(2^8) and passed through the affine transform.
module aes_sbox (
    input  logic                    clk,
    input  logic                    rst,
    input  aes_data_pkg::aes_word_t din,
    output aes_data_pkg::aes_word_t dout
);
    import aes_data_pkg::*;

    aes_word_t sub_word;

    // Shift-and-add product of two field elements.
    function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                acc = acc ^ p;
            end
            p = aes_xtime(p);
        end
        return acc;
    endfunction

    // The inverse is a^254, built from the squares a^2 up to a^128.
    // Zero yields zero here, which the standard treats as its own inverse.
    function automatic aes_byte_t gf_inv(aes_byte_t a);
        aes_byte_t sq;
        aes_byte_t acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);    // Now a^(2^i).
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // Affine map over GF(2), written as a byte XORed with four of its rotations.
    function automatic aes_byte_t affine(aes_byte_t b);
        aes_byte_t s;
        s = b;
        s = s ^ {b[6:0], b[7]};
        s = s ^ {b[5:0], b[7:6]};
        s = s ^ {b[4:0], b[7:5]};
        s = s ^ {b[3:0], b[7:4]};
        return s ^ 8'h63;
    endfunction

    always_comb
    begin
        for (int b = 0; b < 4; b++)
        begin
            sub_word[8*b +: 8] = affine(gf_inv(din[8*b +: 8]));
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dout <= '0;
        end
        else
        begin
            dout <= sub_word;
        end
    end

endmodule

// File: aes_key_stage.sv
// One AES-128 key-expansion step.
// Produces the round key one cycle after its input and a registered copy one cycle later.
module aes_key_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  aes_data_pkg::aes_block_t     key_in,
    input  aes_data_pkg::aes_rcon_t      rcon,
    output aes_data_pkg::aes_round_key_t round_key
);
    import aes_data_pkg::*;

    aes_block_t xor_chain;
    aes_block_t xor_chain_r;
    aes_word_t  rot_word;
    aes_word_t  sub_word;
    aes_block_t now_key;
    aes_block_t next_key;

    // Running XOR of the columns, with the round constant folded into column 0.
    always_comb
    begin
        xor_chain[0] = key_in[0] ^ {rcon, 24'h000000};
        for (int c = 1; c < 4; c++)
        begin
            xor_chain[c] = xor_chain[c-1] ^ key_in[c];
        end
    end

    assign rot_word = {key_in[3][23:0], key_in[3][31:24]};  // RotWord on the last column.

    aes_sbox i_sbox (
        .clk  (clk),
        .rst  (rst),
        .din  (rot_word),
        .dout (sub_word)
    );

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            xor_chain_r <= '0;
            next_key    <= '0;
        end
        else
        begin
            xor_chain_r <= xor_chain;   // Matches the S-box register delay.
            next_key    <= now_key;
        end
    end

    // SubWord reaches every column because each already holds the XOR of those before it.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            now_key[c] = xor_chain_r[c] ^ sub_word;
        end
    end

    assign round_key.now  = now_key;
    assign round_key.next = next_key;

endmodule

// File: aes_cipher_round.sv
// One AES encryption round with two register stages.
// SubBytes, ShiftRows, MixColumns unless it is the last round, then AddRoundKey.
module aes_cipher_round #(
    parameter bit last_round = 1'b0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  aes_data_pkg::aes_block_t state_in,
    input  aes_data_pkg::aes_block_t round_key,
    output aes_data_pkg::aes_block_t state_out
);
    import aes_data_pkg::*;

    aes_block_t sub_state;
    aes_block_t shifted;
    aes_block_t mixed;

    // Column mix over GF(2^8) with the fixed matrix rows 2 3 1 1.
    function automatic aes_word_t mix_column(aes_word_t w);
        aes_byte_t a0;
        aes_byte_t a1;
        aes_byte_t a2;
        aes_byte_t a3;
        aes_byte_t b0;
        aes_byte_t b1;
        aes_byte_t b2;
        aes_byte_t b3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        b0 = aes_xtime(a0) ^ aes_xtime(a1) ^ a1 ^ a2 ^ a3;
        b1 = a0 ^ aes_xtime(a1) ^ aes_xtime(a2) ^ a2 ^ a3;
        b2 = a0 ^ a1 ^ aes_xtime(a2) ^ aes_xtime(a3) ^ a3;
        b3 = aes_xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_xtime(a3);
        return {b0, b1, b2, b3};
    endfunction

    // First register stage sits inside the four S-boxes.
    for (genvar c = 0; c < 4; c++)
    begin : g_sbox
        aes_sbox i_sbox (
            .clk  (clk),
            .rst  (rst),
            .din  (state_in[c]),
            .dout (sub_state[c])
        );
    end

    // Row r rotates left by r columns.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[c][31-8*r -: 8] = sub_state[(c+r)%4][31-8*r -: 8];
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            if (last_round)
            begin
                mixed[c] = shifted[c];  // The final round skips MixColumns.
            end
            else
            begin
                mixed[c] = mix_column(shifted[c]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state_out <= '0;
        end
        else
        begin
            state_out <= mixed ^ round_key;
        end
    end

endmodule

// File: aes_128.sv
// Fully unrolled AES-128 encryption core.
// Start-edge capture, completion FSM, key-schedule chain and round chain.
`include "aes_settings.svh"

module aes_128 (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  aes_data_pkg::aes_block_t  plaintext,
    input  aes_data_pkg::aes_block_t  key,
    output aes_ctrl_pkg::aes_result_t result
);
    import aes_data_pkg::*;
    import aes_ctrl_pkg::*;

    localparam int cnt_w = $clog2(`AES_LATENCY + 1);

    // Round constants of the key schedule, one per stage.
    localparam aes_rcon_t rcon_tab [0:`AES_ROUNDS-1] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    logic            start_r;
    logic            start_edge;
    aes_block_t      state0;
    aes_block_t      key0;
    aes_ctrl_state_t ctrl_state;
    logic [cnt_w-1:0] count;
    aes_round_key_t  round_keys [0:`AES_ROUNDS-1];
    aes_block_t      round_states [0:`AES_ROUNDS];

    assign start_edge = start & ~start_r;

    // Inputs are taken only at the edge, so they may change afterwards.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            start_r <= 1'b0;
            state0  <= '0;
            key0    <= '0;
        end
        else
        begin
            start_r <= start;
            if (start_edge)
            begin
                state0 <= plaintext ^ key;  // Initial AddRoundKey.
                key0   <= key;
            end
        end
    end

    // A new edge reloads the count in any state, so only the newest block is flagged.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ctrl_state <= ctrl_idle;
            count      <= '0;
        end
        else if (start_edge)
        begin
            ctrl_state <= ctrl_busy;
            count      <= cnt_w'(`AES_LATENCY);
        end
        else if (ctrl_state == ctrl_busy)
        begin
            count <= count - cnt_w'(1);
            if (count == cnt_w'(1))
            begin
                ctrl_state <= ctrl_done;
            end
        end
    end

    assign round_states[0] = state0;

    for (genvar i = 0; i < `AES_ROUNDS; i++)
    begin : g_round
        aes_block_t stage_key;

        if (i == 0)
        begin : g_first
            assign stage_key = key0;
        end
        else
        begin : g_chain
            assign stage_key = round_keys[i-1].next;
        end

        aes_key_stage i_key_stage (
            .clk       (clk),
            .rst       (rst),
            .key_in    (stage_key),
            .rcon      (rcon_tab[i]),
            .round_key (round_keys[i])
        );

        aes_cipher_round #(
            .last_round (i == (`AES_ROUNDS - 1))
        ) i_cipher_round (
            .clk       (clk),
            .rst       (rst),
            .state_in  (round_states[i]),
            .round_key (round_keys[i].now),
            .state_out (round_states[i+1])
        );
    end

    assign result.valid = (ctrl_state == ctrl_done);
    assign result.data  = round_states[`AES_ROUNDS];

endmodule

// File: aes_128_checker.sv
// Bound assertions on the control timing of the AES-128 core.
// Reset clear, start-to-valid latency, start-edge clear and held result data.
`include "aes_settings.svh"

module aes_128_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      start,
    input aes_ctrl_pkg::aes_result_t result
);
    logic start_d;
    logic start_edge;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            start_d <= 1'b0;
        end
        else
        begin
            start_d <= start;
        end
    end

    assign start_edge = start & ~start_d;  // Same edge the core detects.

    assert property (@(posedge clk) rst |=> !result.valid)
        else $error("result.valid is high in the cycle after reset");

    // The flag register loads at the latency edge, so its sampled rise shows one clock later.
    assert property (@(posedge clk) disable iff (rst)
        $rose(result.valid) |-> $past(start_edge, `AES_LATENCY + 1))
        else $error("result.valid rose without a start edge at the expected latency");

    assert property (@(posedge clk) disable iff (rst) start_edge |=> !result.valid)
        else $error("result.valid stayed high after a start edge");

    assert property (@(posedge clk) disable iff (rst)
        (result.valid && $past(result.valid)) |-> $stable(result.data))
        else $error("result.data changed while result.valid was held");

endmodule

bind aes_128 aes_128_checker i_aes_128_checker (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .result (result)
);

// File: aes_128_tb.sv
// Testbench for the AES-128 core driven by vectors from the stim file.
// Checks ciphertext, start-to-valid latency, held results, restarts and mid-run reset.
`include "aes_settings.svh"

module aes_128_tb;
    import aes_data_pkg::*;
    import aes_ctrl_pkg::*;

    localparam int half_period = 10;
    localparam int wait_limit  = 40;

    logic        clk;
    logic        rst;
    logic        start;
    aes_block_t  plaintext;
    aes_block_t  key;
    aes_result_t result;

    integer seed;
    int     value_errors;
    int     other_errors;

    aes_128 i_aes_128 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .plaintext (plaintext),
        .key       (key),
        .result    (result)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(half_period) clk = ~clk;
        end
    end

    task automatic check_result(input string name, input aes_result_t expected,
                                input aes_result_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_valid(input string name, input bit expected, input logic actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
        end
    endtask

    // The core samples its inputs only at the edge, so later noise must not matter.
    task automatic scramble_inputs();
        plaintext = {$random(seed), $random(seed), $random(seed), $random(seed)};
        key       = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // Called at the falling edge where start goes high; counts cycles from the next rise.
    task automatic wait_for_valid(input int hold_cycles, output bit seen);
        int k;
        seen = 1'b0;
        k    = 0;
        while (!seen && k < wait_limit)
        begin
            @(negedge clk);
            check_valid("result.valid", k >= `AES_LATENCY, result.valid);
            seen = (result.valid === 1'b1);
            if (k + 1 >= hold_cycles)
            begin
                start = 1'b0;
            end
            scramble_inputs();
            k++;
        end
        if (!seen)
        begin
            other_errors++;
            $display("Timeout: result.valid stayed low for %0d cycles after a start edge",
                     wait_limit);
        end
    endtask

    task automatic hold_result(input aes_block_t expected, input int cycles);
        aes_result_t exp_res;
        exp_res.valid = 1'b1;
        exp_res.data  = expected;
        repeat (cycles)
        begin
            @(negedge clk);
            check_result("result", exp_res, result);
            scramble_inputs();
        end
    endtask

    task automatic run_unflagged(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            check_valid("result.valid", 1'b0, result.valid);
            start = 1'b0;
            scramble_inputs();
        end
    endtask

    task automatic run_vector(input aes_block_t vec_key, input aes_block_t vec_pt,
                              input aes_block_t vec_ct, input int hold_cycles,
                              input int extra_hold);
        aes_result_t exp_res;
        bit          seen;
        int          gap;
        exp_res.valid = 1'b1;
        exp_res.data  = vec_ct;
        key           = vec_key;
        plaintext     = vec_pt;
        start         = 1'b1;
        wait_for_valid(hold_cycles, seen);
        if (seen)
        begin
            check_result("result", exp_res, result);
        end
        gap = 2 + (($random(seed) & 32'h7fff_ffff) % 6);
        hold_result(vec_ct, gap + extra_hold);
    endtask

    initial
    begin
        integer           fd;
        integer           n;
        int               vectors;
        logic [8*16-1:0]  word;
        logic [8*256-1:0] line;
        logic [127:0]     vk;
        logic [127:0]     vp;
        logic [127:0]     vc;

        seed         = 32'h9454_07b9;
        value_errors = 0;
        other_errors = 0;
        vectors      = 0;
        rst          = 1'b1;
        start        = 1'b0;
        plaintext    = '0;
        key          = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_result("result", '0, result);

        fd = $fopen("aes_128_stim.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open the stimulus file aes_128_stim.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                word = '0;
                n    = $fscanf(fd, "%s", word);
                if (n == 1 && word == "#")
                begin
                    n = $fgets(line, fd);
                end
                else if (n == 1)
                begin
                    n = $fscanf(fd, "%h %h %h", vk, vp, vc);
                    vectors++;
                    if (n != 3)
                    begin
                        other_errors++;
                        $display("Vector line %0d is missing a hex field", vectors);
                    end
                    else if (word == "enc")
                    begin
                        run_vector(vk, vp, vc, 1, 0);
                    end
                    else if (word == "hold")
                    begin
                        run_vector(vk, vp, vc, 5, 8);
                    end
                    else if (word == "restart")
                    begin
                        scramble_inputs();      // A throwaway first block.
                        start = 1'b1;
                        run_unflagged(7);
                        run_vector(vk, vp, vc, 1, 0);
                    end
                    else if (word == "reset")
                    begin
                        key       = vk;
                        plaintext = vp;
                        start     = 1'b1;
                        run_unflagged(10);
                        rst = 1'b1;
                        @(negedge clk);
                        check_result("result", '0, result);
                        @(negedge clk);
                        rst = 1'b0;
                        // The cleared run must stay unflagged past its old finishing point.
                        run_unflagged(12);
                        run_vector(vk, vp, vc, 1, 0);
                    end
                    else
                    begin
                        other_errors++;
                        $display("Vector line %0d has an unknown command", vectors);
                    end
                end
            end
            $fclose(fd);
        end

        if (vectors == 0)
        begin
            other_errors++;
            $display("The stimulus file held no vectors");
        end
        $display("Vectors run: %0d, value errors: %0d, other errors: %0d",
                 vectors, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: aes_128_stim.txt
# Columns: command, key, plaintext, expected ciphertext, all 128-bit hex.
# Commands: enc, hold (start held high), restart (new edge mid-run), reset (rst mid-run).
enc 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
enc 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
enc 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
enc 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
hold 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
restart 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
enc 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
reset 00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34
enc 80000000000000000000000000000000 00000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8
enc 00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
hold 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
restart 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
reset 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
enc 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97

// File: sources.f
+incdir+.
aes_data_pkg.sv
aes_ctrl_pkg.sv
aes_sbox.sv
aes_key_stage.sv
aes_cipher_round.sv
aes_128.sv
aes_128_checker.sv
aes_128_tb.sv
